/* Bender.yml */
package:
  name: lsu

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lsu_pkg.sv
      - hdl/lsu_issue.sv
      - hdl/lsu_dmem.sv
      - hdl/lsu_load_align.sv
      - hdl/lsu_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/lsu_tb.sv

/* filelist.f */
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_issue.sv
hdl/lsu_dmem.sv
hdl/lsu_load_align.sv
hdl/lsu_top.sv
test/lsu_tb.sv

/* hdl/lsu_dmem.sv */
// Data RAM with byte-lane writes, alignment check and registered response

`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_dmem (
  input  logic              clk,
  input  logic              rstn,
  input  logic              dmem_req,
  input  logic              exc_pass,   // Carries exceptions past the RAM
  input  lsu_pkg::lsu_req_t dmem_r,
  output logic              dmem_ack,
  output lsu_pkg::lsu_rsp_t dmem_s
);

  logic [`LSU_XLEN-1:0]   mem [0:`LSU_RAM_WORDS-1];
  logic [`LSU_RAM_AW-1:0] idx;
  logic [2:0]             ofs;
  logic                   misaligned;
  logic [7:0]             be_base;
  logic [7:0]             be;
  logic [`LSU_EXC_W-1:0]  exc_add;   // Misaligned cause for this access

  assign idx = dmem_r.adr[`LSU_RAM_AW+2:3];  // Upper bits wrap
  assign ofs = dmem_r.adr[2:0];

  ////////////////////
  // Alignment, lanes
  ////////////////////

  always_comb begin
    case (dmem_r.size)
      lsu_pkg::BYTE: begin
        misaligned = 1'b0;
        be_base    = 8'h01;
      end
      lsu_pkg::HWORD: begin
        misaligned = ofs[0];
        be_base    = 8'h03;
      end
      lsu_pkg::WORD: begin
        misaligned = |ofs[1:0];
        be_base    = 8'h0f;
      end
      lsu_pkg::DWORD: begin
        misaligned = |ofs;
        be_base    = 8'hff;
      end
      default: begin  // Only on exc_pass
        misaligned = 1'b0;
        be_base    = 8'h00;
      end
    endcase
  end

  assign be = be_base << ofs;  // Cannot overflow once aligned

  always_comb begin
    exc_add = '0;
    if (dmem_req && misaligned) begin
      if (dmem_r.we) exc_add[lsu_pkg::EXC_STORE_MISALIGNED] = 1'b1;
      else           exc_add[lsu_pkg::EXC_LOAD_MISALIGNED]  = 1'b1;
    end
  end

  ////////////////////
  // Storage
  ////////////////////

  // Byte-lane writes into a RAM zeroed by reset
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int w = 0; w < `LSU_RAM_WORDS; w++) mem[w] <= '0;
    end else if (dmem_req && dmem_r.we && !misaligned) begin
      for (int b = 0; b < 8; b++) begin
        if (be[b]) mem[idx][8*b +: 8] <= dmem_r.wdata[8*b +: 8];
      end
    end
  end

  ////////////////////
  // Response
  ////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) dmem_ack <= 1'b0;
    else       dmem_ack <= dmem_req | exc_pass;
  end

  // Read before write on the same edge; a later load sees the store
  always_ff @(posedge clk) begin
    if (dmem_req || exc_pass) begin
      dmem_s.q           <= mem[idx];
      dmem_s.lane        <= ofs;
      dmem_s.size        <= dmem_r.size;
      dmem_s.we          <= dmem_r.we;
      dmem_s.ld_unsigned <= dmem_r.ld_unsigned;
      dmem_s.exc         <= dmem_r.exc | exc_add;
    end
  end

  // Ack exactly one cycle after each request
  a_ack_follows: assert property (@(posedge clk) disable iff (!rstn)
    (dmem_req || exc_pass) |=> dmem_ack);

endmodule

/* hdl/lsu_issue.sv */
// Load/store decode, address and store-data generation, registered memory request

`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_issue (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  ex_stall,     // Holds off acceptance only
  input  logic                  id_valid,
  input  logic [31:0]           id_instr,
  input  logic [`LSU_XLEN-1:0]  opA,
  input  logic [`LSU_XLEN-1:0]  opB,
  input  logic [`LSU_EXC_W-1:0] id_exception,
  input  logic [1:0]            st_xlen,      // xlen_mode_e coding
  output logic                  dmem_req,
  output logic                  exc_pass,
  output lsu_pkg::lsu_req_t     dmem_r
);

  ////////////////////
  // Decode
  ////////////////////

  lsu_pkg::opcode_e     opcode;
  lsu_pkg::ls_func_e    func3;
  lsu_pkg::mem_size_e   size;
  logic                 accept;
  logic                 xlen32;
  logic                 is_load;
  logic                 is_store;
  logic                 ld_legal;
  logic                 st_legal;
  logic                 mem_ok;       // Recognized load/store in this mode
  logic                 has_exc;
  logic [`LSU_XLEN-1:0] imm_s;
  logic [`LSU_XLEN-1:0] adr;
  logic [`LSU_XLEN-1:0] wdata;
  logic [5:0]           lane_sh;      // Byte offset in bits

  assign opcode   = lsu_pkg::opcode_e'(id_instr[6:2]);
  assign func3    = lsu_pkg::ls_func_e'(id_instr[14:12]);
  assign accept   = id_valid & ~ex_stall;
  assign xlen32   = (st_xlen == lsu_pkg::RV32I);
  assign is_load  = (opcode == lsu_pkg::OPC_LOAD);
  assign is_store = (opcode == lsu_pkg::OPC_STORE);
  assign has_exc  = |id_exception;

  // S-type immediate, sign-extended
  assign imm_s = {{(`LSU_XLEN-12){id_instr[31]}}, id_instr[31:25], id_instr[11:7]};

  // Legal load forms
  always_comb begin
    case (func3)
      lsu_pkg::LB, lsu_pkg::LH, lsu_pkg::LW,
      lsu_pkg::LBU, lsu_pkg::LHU: ld_legal = 1'b1;
      lsu_pkg::LD, lsu_pkg::LWU:  ld_legal = ~xlen32;  // Doubleword forms, RV64 only
      default:                    ld_legal = 1'b0;
    endcase
  end

  // Legal store forms, SB..SD share the LB..LD codes
  always_comb begin
    case (func3)
      lsu_pkg::LB, lsu_pkg::LH, lsu_pkg::LW: st_legal = 1'b1;
      lsu_pkg::LD:                           st_legal = ~xlen32;  // SD
      default:                               st_legal = 1'b0;
    endcase
  end

  assign mem_ok = (is_load & ld_legal) | (is_store & st_legal);

  ////////////////////
  // Address and data
  ////////////////////

  assign adr     = is_store ? opA + imm_s : opA + opB;
  assign lane_sh = {adr[2:0], 3'b000};

  // Access size from func3[1:0]; unsigned forms map onto the same sizes
  always_comb begin
    case (func3)
      lsu_pkg::LB, lsu_pkg::LBU: size = lsu_pkg::BYTE;
      lsu_pkg::LH, lsu_pkg::LHU: size = lsu_pkg::HWORD;
      lsu_pkg::LW, lsu_pkg::LWU: size = lsu_pkg::WORD;
      lsu_pkg::LD:               size = lsu_pkg::DWORD;
      default:                   size = lsu_pkg::UNDEF_SIZE;
    endcase
  end

  // Move store data into its byte lane
  always_comb begin
    case (size)
      lsu_pkg::BYTE:  wdata = `LSU_XLEN'(opB[7:0]) << lane_sh;
      lsu_pkg::HWORD: wdata = `LSU_XLEN'(opB[15:0]) << lane_sh;
      lsu_pkg::WORD:  wdata = `LSU_XLEN'(opB[31:0]) << lane_sh;
      default:        wdata = opB;  // Doubleword, no shift
    endcase
  end

  ////////////////////
  // Request register
  ////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      dmem_req <= 1'b0;
      exc_pass <= 1'b0;
    end else begin
      dmem_req <= accept & mem_ok & ~has_exc;
      exc_pass <= accept & has_exc;  // Any opcode, so the vector reaches writeback
    end
  end

  // Payload, qualified by the strobes above
  always_ff @(posedge clk) begin
    if (accept) begin
      dmem_r.adr         <= adr;
      dmem_r.wdata       <= wdata;
      dmem_r.size        <= mem_ok ? size : lsu_pkg::UNDEF_SIZE;
      dmem_r.we          <= is_store;
      dmem_r.ld_unsigned <= is_load & func3[2];  // LBU, LHU, LWU
      dmem_r.exc         <= id_exception;
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  // A request either touches the RAM or only carries exceptions
  a_req_excl: assert property (@(posedge clk) disable iff (!rstn)
    !(dmem_req && exc_pass));

  a_adr_known: assert property (@(posedge clk) disable iff (!rstn)
    dmem_req |-> !$isunknown(dmem_r.adr));

endmodule

/* hdl/lsu_load_align.sv */
// Load lane select, sign/zero extension and registered writeback

`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_load_align (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  dmem_ack,
  input  lsu_pkg::lsu_rsp_t     dmem_s,
  output logic                  wb_valid,
  output logic [`LSU_XLEN-1:0]  wb_data,
  output logic [`LSU_EXC_W-1:0] wb_exception
);

  logic [`LSU_XLEN-1:0] shifted;  // Addressed byte moved down to bit 0
  logic [`LSU_XLEN-1:0] ext;
  logic [`LSU_XLEN-1:0] wb_nxt;
  logic                 sgn;      // Replicated sign bit, zero for unsigned

  assign shifted = dmem_s.q >> {dmem_s.lane, 3'b000};

  ////////////////////
  // Extension
  ////////////////////

  always_comb begin
    sgn = 1'b0;
    ext = '0;
    case (dmem_s.size)
      lsu_pkg::BYTE: begin
        sgn = ~dmem_s.ld_unsigned & shifted[7];
        ext = {{(`LSU_XLEN-8){sgn}}, shifted[7:0]};
      end
      lsu_pkg::HWORD: begin
        sgn = ~dmem_s.ld_unsigned & shifted[15];
        ext = {{(`LSU_XLEN-16){sgn}}, shifted[15:0]};
      end
      lsu_pkg::WORD: begin
        sgn = ~dmem_s.ld_unsigned & shifted[31];  // LW vs LWU
        ext = {{(`LSU_XLEN-32){sgn}}, shifted[31:0]};
      end
      lsu_pkg::DWORD: ext = shifted;
      default:        ext = '0;  // Undefined size carries no data
    endcase
  end

  // Stores and faulted accesses write back nothing
  assign wb_nxt = (dmem_s.we || |dmem_s.exc) ? '0 : ext;

  ////////////////////
  // Writeback stage
  ////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) wb_valid <= 1'b0;
    else       wb_valid <= dmem_ack;
  end

  always_ff @(posedge clk) begin
    if (dmem_ack) begin
      wb_data      <= wb_nxt;
      wb_exception <= dmem_s.exc;
    end
  end

endmodule

/* hdl/lsu_pkg.sv */
// Load/store package: opcode, size, func3, mode and cause enums, request and response structs

`include "lsu_settings.svh"

package lsu_pkg;

  ////////////////////
  // Encodings
  ////////////////////

  // Major opcode, instr[6:2]
  typedef enum logic [4:0] {
    OPC_LOAD  = 5'b00000,
    OPC_STORE = 5'b01000
  } opcode_e;

  // Access size on the memory side
  typedef enum logic [2:0] {
    BYTE       = 3'b000,
    HWORD      = 3'b001,
    WORD       = 3'b010,
    DWORD      = 3'b011,
    UNDEF_SIZE = 3'b111
  } mem_size_e;

  // func3 of loads; SB/SH/SW/SD reuse the LB/LH/LW/LD codes
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LD  = 3'b011,  // RV64 only
    LBU = 3'b100,
    LHU = 3'b101,
    LWU = 3'b110   // RV64 only
  } ls_func_e;

  // Same coding as the MXL field
  typedef enum logic [1:0] {
    RV32I = 2'b01,
    RV64I = 2'b10
  } xlen_mode_e;

  // Bit index into the exception vector
  typedef enum int unsigned {
    EXC_INSTR_MISALIGNED   = 0,
    EXC_INSTR_ACCESS_FAULT = 1,
    EXC_ILLEGAL_INSTR      = 2,
    EXC_BREAKPOINT         = 3,
    EXC_LOAD_MISALIGNED    = 4,
    EXC_LOAD_ACCESS_FAULT  = 5,
    EXC_STORE_MISALIGNED   = 6,
    EXC_STORE_ACCESS_FAULT = 7
  } exc_cause_e;

  ////////////////////
  // Bundles
  ////////////////////

  // Issue to RAM
  typedef struct packed {
    logic [`LSU_XLEN-1:0]  adr;
    logic [`LSU_XLEN-1:0]  wdata;        // Already in its byte lane
    mem_size_e             size;
    logic                  we;
    logic                  ld_unsigned;
    logic [`LSU_EXC_W-1:0] exc;          // Rides along with the instruction
  } lsu_req_t;

  // RAM to load align
  typedef struct packed {
    logic [`LSU_XLEN-1:0]  q;            // Whole doubleword
    logic [2:0]            lane;         // Byte offset within it
    mem_size_e             size;
    logic                  we;
    logic                  ld_unsigned;
    logic [`LSU_EXC_W-1:0] exc;
  } lsu_rsp_t;

endpackage

/* hdl/lsu_settings.svh */
// Global widths and RAM geometry for the load/store path

`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

////////////////////
// Datapath
////////////////////

`define LSU_XLEN      64   // Data and address width
`define LSU_EXC_W     16   // Exception vector width

////////////////////
// Data RAM
////////////////////

`define LSU_RAM_WORDS 256  // Depth in doublewords, 2 KB
`define LSU_RAM_AW    8    // Doubleword index bits, adr[10:3]

`endif

/* hdl/lsu_top.sv */
// Load/store path top: issue, data RAM and load align

`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_top (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  ex_stall,
  input  logic                  id_valid,
  input  logic [31:0]           id_instr,
  input  logic [`LSU_XLEN-1:0]  opA,
  input  logic [`LSU_XLEN-1:0]  opB,
  input  logic [`LSU_EXC_W-1:0] id_exception,
  input  logic [1:0]            st_xlen,
  output logic                  wb_valid,
  output logic [`LSU_XLEN-1:0]  wb_data,
  output logic [`LSU_EXC_W-1:0] wb_exception
);

  // Issue to RAM
  logic              dmem_req;
  logic              exc_pass;
  lsu_pkg::lsu_req_t dmem_r;

  // RAM to align
  logic              dmem_ack;
  lsu_pkg::lsu_rsp_t dmem_s;

  lsu_issue issue0 (
    .clk          (clk),
    .rstn         (rstn),
    .ex_stall     (ex_stall),
    .id_valid     (id_valid),
    .id_instr     (id_instr),
    .opA          (opA),
    .opB          (opB),
    .id_exception (id_exception),
    .st_xlen      (st_xlen),
    .dmem_req     (dmem_req),
    .exc_pass     (exc_pass),
    .dmem_r       (dmem_r)
  );

  lsu_dmem dmem0 (
    .clk      (clk),
    .rstn     (rstn),
    .dmem_req (dmem_req),
    .exc_pass (exc_pass),
    .dmem_r   (dmem_r),
    .dmem_ack (dmem_ack),
    .dmem_s   (dmem_s)
  );

  lsu_load_align align0 (
    .clk          (clk),
    .rstn         (rstn),
    .dmem_ack     (dmem_ack),
    .dmem_s       (dmem_s),
    .wb_valid     (wb_valid),
    .wb_data      (wb_data),
    .wb_exception (wb_exception)
  );

endmodule

/* test/lsu_tb.sv */
// Testbench for lsu_top with random load/store stimulus, a byte-image model and writeback checks

`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_tb;

  typedef struct packed {
    logic [63:0] data;
    logic [15:0] exc;
    logic [31:0] cyc;   // Cycle in which wb_valid is due
  } wb_exp_t;

  logic        clk;
  logic        rstn;
  logic        ex_stall;
  logic        id_valid;
  logic [31:0] id_instr;
  logic [63:0] opA;
  logic [63:0] opB;
  logic [15:0] id_exception;
  logic [1:0]  st_xlen;
  wire         wb_valid;
  wire  [63:0] wb_data;
  wire  [15:0] wb_exception;

  integer      seed = 49;
  int          cyc;
  int          errors;
  int          checks;
  logic [7:0]  img [0:`LSU_RAM_WORDS*8-1];  // Byte image of the RAM
  wb_exp_t     exp_q[$];
  wb_exp_t     mon_e;

  lsu_top dut0 (
    .clk(clk), .rstn(rstn), .ex_stall(ex_stall), .id_valid(id_valid),
    .id_instr(id_instr), .opA(opA), .opB(opB), .id_exception(id_exception),
    .st_xlen(st_xlen), .wb_valid(wb_valid), .wb_data(wb_data),
    .wb_exception(wb_exception)
  );

  always #20 clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  ////////////////////
  // Writeback monitor
  ////////////////////

  always @(negedge clk) begin
    if (rstn && wb_valid) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected writeback at cycle %0d", cyc);
        errors++;
      end else begin
        mon_e = exp_q.pop_front();
        checks++;
        if (mon_e.cyc != cyc) begin
          $display("Writeback at cycle %0d was due at cycle %0d", cyc, mon_e.cyc);
          errors++;
        end
        if (wb_data !== mon_e.data) begin
          $display("Error: wb_data got %h expected %h", wb_data, mon_e.data);
          errors++;
        end
        if (wb_exception !== mon_e.exc) begin
          $display("Error: wb_exception got %h expected %h", wb_exception, mon_e.exc);
          errors++;
        end
      end
    end else if (rstn && exp_q.size() != 0 && exp_q[0].cyc <= cyc) begin
      $display("Writeback due at cycle %0d never came", exp_q[0].cyc);
      errors++;
      mon_e = exp_q.pop_front();
    end
  end

  ////////////////////
  // Drive and model
  ////////////////////

  // One cycle of inputs; model decides on what the DUT accepts
  task automatic send(input logic [31:0] instr, input logic [63:0] a, input logic [63:0] b,
                      input logic [15:0] exc, input logic valid, input logic stall);
    logic [63:0] adr;
    logic [63:0] val;
    logic [2:0]  f3;
    logic [3:0]  n;
    logic        ld;
    logic        st;
    logic        rv32;
    logic        legal;
    wb_exp_t     e;
    @(posedge clk);
    #2;
    id_valid     = valid;
    ex_stall     = stall;
    id_instr     = instr;
    opA          = a;
    opB          = b;
    id_exception = exc;
    f3    = instr[14:12];
    ld    = (instr[6:2] == 5'b00000);
    st    = (instr[6:2] == 5'b01000);
    rv32  = (st_xlen == lsu_pkg::RV32I);
    n     = 4'd1 << f3[1:0];  // Bytes in the access
    adr   = st ? a + {{52{instr[31]}}, instr[31:25], instr[11:7]} : a + b;
    legal = ld ? (f3 != 3'd7) && !(rv32 && (f3 == 3'd3 || f3 == 3'd6))
               : st && (f3 < 3'd4) && !(rv32 && f3 == 3'd3);
    e.data = '0;
    e.exc  = exc;
    e.cyc  = cyc + 3;
    if (valid && !stall && (exc != 0 || legal)) begin
      if (exc == 0 && (adr[2:0] & (n - 1)) != 0) begin
        e.exc[st ? lsu_pkg::EXC_STORE_MISALIGNED : lsu_pkg::EXC_LOAD_MISALIGNED] = 1'b1;
      end else if (exc == 0 && st) begin
        for (int i = 0; i < n; i++) img[adr[10:0] + i] = b[8*i +: 8];
      end else if (exc == 0) begin
        val = '0;
        for (int i = 0; i < 8; i++)   // Upper bytes copy the sign unless unsigned
          val[8*i +: 8] = (i < n) ? img[adr[10:0] + i] : {8{!f3[2] && val[8*n-1]}};
        e.data = val;
      end
      exp_q.push_back(e);
    end
  endtask

  // Random address, aligned to the size unless mis
  function automatic logic [10:0] rand_adr(input logic [2:0] f3, input logic mis);
    logic [10:0] t;
    t = $random(seed);
    t = t & ~((11'd1 << f3[1:0]) - 11'd1);
    if (mis) t[0] = 1'b1;
    return t;
  endfunction

  // Load or store hitting byte t of the image; upper address bits random
  task automatic mem_op(input logic st, input logic [2:0] f3, input logic [10:0] t,
                        input logic [15:0] exc, input logic valid, input logic stall);
    logic [63:0] a;
    logic [63:0] sum;
    logic [11:0] imm;
    a         = {$random(seed), $random(seed)};
    sum       = {$random(seed), $random(seed)};
    sum[10:0] = t;
    imm       = $random(seed);
    if (st)
      send({imm[11:5], 5'd3, 5'd1, f3, imm[4:0], 7'b0100011}, sum - {{52{imm[11]}}, imm},
           {$random(seed), $random(seed)}, exc, valid, stall);
    else
      send({12'h000, 5'd1, f3, 5'd2, 7'b0000011}, a, sum - a, exc, valid, stall);
  endtask

  // Idle inputs, wait for the queue to empty, then a few quiet cycles
  task automatic drain();
    int waited;
    @(posedge clk);
    #2;
    id_valid = 1'b0;
    ex_stall = 1'b0;
    waited   = 0;
    while (exp_q.size() != 0 && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout: %0d writebacks missing after 20 cycles", exp_q.size());
      errors += exp_q.size();
      exp_q.delete();
    end
    repeat (4) @(posedge clk);  // Catches stray writebacks
    #2;
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    logic [10:0] t;
    logic [2:0]  f3;
    logic [15:0] ev;
    clk = 1'b0;
    rstn = 1'b0;
    ex_stall = 1'b0;
    id_valid = 1'b0;
    id_instr = '0;
    opA = '0;
    opB = '0;
    id_exception = '0;
    st_xlen = lsu_pkg::RV64I;
    cyc = 0;
    errors = 0;
    checks = 0;
    for (int i = 0; i < `LSU_RAM_WORDS*8; i++) img[i] = 8'h00;
    repeat (8) @(posedge clk);
    #2;
    rstn = 1'b1;

    for (int w = 0; w < `LSU_RAM_WORDS; w++)  // Random fill with one SD per doubleword
      mem_op(1'b1, 3'd3, 11'(w * 8), 16'h0, 1'b1, 1'b0);
    drain();
    for (int i = 0; i < 70; i++) begin  // Aligned loads, all func3
      f3 = i % 7;
      mem_op(1'b0, f3, rand_adr(f3, 1'b0), 16'h0, 1'b1, 1'b0);
    end
    drain();
    for (int i = 0; i < 40; i++) begin  // Store then LD of it the next cycle
      f3 = i % 4;
      t  = rand_adr(f3, 1'b0);
      mem_op(1'b1, f3, t, 16'h0, 1'b1, 1'b0);
      mem_op(1'b0, 3'd3, {t[10:3], 3'b000}, 16'h0, 1'b1, 1'b0);
    end
    drain();
    for (int i = 0; i < 30; i++) begin  // Misaligned access, then LD shows no change
      f3 = 3'd1 + i % 3;
      t  = rand_adr(f3, 1'b1);
      mem_op(i % 2 == 1, f3, t, 16'h0, 1'b1, 1'b0);
      mem_op(1'b0, 3'd3, {t[10:3], 3'b000}, 16'h0, 1'b1, 1'b0);
    end
    drain();
    for (int i = 0; i < 30; i++) begin  // Incoming exceptions on any opcode
      ev = $random(seed);
      ev = (ev == 16'h0) ? 16'h0004 : ev;
      f3 = i % 4;
      t  = rand_adr(f3, 1'b0);
      if (i % 3 == 2)
        send({25'h0, 7'b0010011}, {$random(seed), $random(seed)}, 64'h0, ev, 1'b1, 1'b0);
      else
        mem_op(i % 3 == 1, f3, t, ev, 1'b1, 1'b0);
      mem_op(1'b0, 3'd3, {t[10:3], 3'b000}, 16'h0, 1'b1, 1'b0);
    end
    drain();

    st_xlen = lsu_pkg::RV32I;  // Doubleword forms become bubbles
    for (int i = 0; i < 40; i++) begin
      f3 = $random(seed);
      mem_op($random(seed) & 1, f3, rand_adr(f3, 1'b0), 16'h0, 1'b1, 1'b0);
      send({25'h0, 7'b0110011}, {$random(seed), $random(seed)}, 64'h8, 16'h0, 1'b1, 1'b0);
    end
    drain();
    st_xlen = lsu_pkg::RV64I;

    for (int i = 0; i < 400; i++) begin  // Back-to-back traffic with random stalls
      f3 = $random(seed);
      ev = (($random(seed) & 15) == 0) ? 16'h0008 : 16'h0000;
      if (i % 10 == 0)
        send({25'h0, 7'b0110111}, {$random(seed), $random(seed)}, 64'h0, 16'h0, 1'b1, 1'b0);
      mem_op($random(seed) & 1, f3, rand_adr(f3, ($random(seed) & 7) == 0), ev,
             ($random(seed) & 3) != 0, ($random(seed) & 3) == 0);
    end
    drain();

    $display("%0d writebacks checked, %0d errors", checks, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule
